// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    parameter int xlen = 32;

    typedef enum logic [4:0] {
        // arithmetic and compare
        ADD,
        ADDU,
        SUB,
        SUBU,
        SLT,
        SLTU,
        // logic
        AND,
        OR,
        NOR,
        XOR,
        LUI,
        // shifts and bit counts
        SLL,
        SRL,
        SRA,
        ROTR,
        CLO,
        CLZ,
        // multiply/divide block
        MULT,
        MULTU,
        MADD,
        MADDU,
        DIV,
        DIVU,
        MTHI,
        MTLO,
        MFHI,
        MFLO
    } alu_op_e;

    // everything that touches hi/lo goes to the multiply/divide block
    function automatic logic is_muldiv(alu_op_e op);
        return op inside {MULT, MULTU, MADD, MADDU, DIV, DIVU, MTHI, MTLO, MFHI, MFLO};
    endfunction

endpackage

`default_nettype wire

// ==== common/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    // request into the execution unit
    typedef struct packed {
        isa_pkg::alu_op_e          op;
        logic [isa_pkg::xlen-1:0]  a;  // a[4:0] is the shift amount
        logic [isa_pkg::xlen-1:0]  b;
    } exu_req_t;

    typedef struct packed {
        logic [isa_pkg::xlen-1:0]  y;
        logic                      overflow;  // add/sub only
    } exu_resp_t;

    // alu_master to muldiv_unit
    typedef struct packed {
        isa_pkg::alu_op_e          op;
        logic [isa_pkg::xlen-1:0]  a;
        logic [isa_pkg::xlen-1:0]  b;
    } muldiv_req_t;

endpackage

`default_nettype wire

// ==== logic/int_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module int_alu (
    input  isa_pkg::alu_op_e          op,
    input  logic [isa_pkg::xlen-1:0]  a,
    input  logic [isa_pkg::xlen-1:0]  b,
    output logic [isa_pkg::xlen-1:0]  y,
    output logic                      overflow
);
    import isa_pkg::*;

    logic [xlen-1:0]    sum;
    logic [xlen-1:0]    diff;
    logic [4:0]         sh;
    logic [2*xlen-1:0]  rot;
    logic [5:0]         lead_ones;
    logic [5:0]         lead_zeros;

    assign sh   = a[4:0];
    assign sum  = a + b;
    assign diff = a - b;
    assign rot  = {b, b} >> sh;  // low half is b rotated right

    // last hit in an upward scan is the first one seen from bit 31
    always_comb begin
        lead_ones  = 6'd32;
        lead_zeros = 6'd32;
        for (int i = 0; i < xlen; i++) begin
            if (!a[i]) begin
                lead_ones = 6'(xlen - 1 - i);
            end
            if (a[i]) begin
                lead_zeros = 6'(xlen - 1 - i);
            end
        end
    end

    always_comb begin
        y        = '0;
        overflow = 1'b0;
        case (op)
            ADD: begin
                y        = sum;
                overflow = (a[31] == b[31]) && (sum[31] != a[31]);
            end
            ADDU: y = sum;
            SUB: begin
                y        = diff;
                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            SUBU: y = diff;
            SLT:  y = xlen'($signed(a) < $signed(b));
            SLTU: y = xlen'(a < b);
            AND:  y = a & b;
            OR:   y = a | b;
            NOR:  y = ~(a | b);
            XOR:  y = a ^ b;
            LUI:  y = {b[15:0], 16'b0};
            SLL:  y = b << sh;
            SRL:  y = b >> sh;
            SRA:  y = $signed(b) >>> sh;
            ROTR: y = rot[xlen-1:0];
            CLO:  y = xlen'(lead_ones);
            CLZ:  y = xlen'(lead_zeros);
            default: begin
                y = '0;  // muldiv ops never land here
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== muldiv/mul_iter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mul_iter #(
    parameter int MUL_BITS = 2
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic [isa_pkg::xlen-1:0]    ma,
    input  logic [isa_pkg::xlen-1:0]    mb,
    output logic                        done,
    output logic [2*isa_pkg::xlen-1:0]  product
);
    localparam int steps = 32 / MUL_BITS;

    logic [63:0]  acc;
    logic [63:0]  mcand;
    logic [31:0]  mplier;
    logic [63:0]  partial;
    logic [5:0]   cnt;
    logic         busy;

    // multiplicand times the low MUL_BITS multiplier bits
    always_comb begin
        partial = '0;
        for (int i = 0; i < MUL_BITS; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= 6'(steps);
            end else if (busy) begin
                cnt <= cnt - 6'd1;
                if (cnt == 6'd1) begin  // last step
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= {32'b0, ma};
            mplier <= mb;
        end else if (busy) begin
            acc    <= acc + partial;
            mcand  <= mcand << MUL_BITS;
            mplier <= mplier >> MUL_BITS;
        end
    end

    assign product = acc;

endmodule

`default_nettype wire

// ==== muldiv/div_iter.sv ====
`timescale 1ns/100ps
`default_nettype none

module div_iter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start,
    input  logic [isa_pkg::xlen-1:0]  da,
    input  logic [isa_pkg::xlen-1:0]  db,
    output logic                      done,
    output logic [isa_pkg::xlen-1:0]  quotient,
    output logic [isa_pkg::xlen-1:0]  remainder
);
    logic [31:0]  rem;
    logic [31:0]  quo;  // dividend shifts out, quotient bits shift in
    logic [31:0]  dvsr;
    logic [32:0]  rem_sh;
    logic [32:0]  rem_sub;
    logic         ge;
    logic [5:0]   cnt;
    logic         busy;

    assign rem_sh  = {rem, quo[31]};
    assign rem_sub = rem_sh - {1'b0, dvsr};
    assign ge      = rem_sh >= {1'b0, dvsr};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= 6'd32;
            end else if (busy) begin
                cnt <= cnt - 6'd1;
                if (cnt == 6'd1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // restoring step
    // a zero divisor subtracts nothing every step, so the quotient fills with
    // ones and the whole dividend ends up in rem
    always_ff @(posedge clk) begin
        if (start) begin
            rem  <= '0;
            quo  <= da;
            dvsr <= db;
        end else if (busy) begin
            rem <= ge ? rem_sub[31:0] : rem_sh[31:0];
            quo <= {quo[30:0], ge};
        end
    end

    assign quotient  = quo;
    assign remainder = rem;

endmodule

`default_nettype wire

// ==== muldiv/muldiv_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit #(
    parameter int MUL_BITS = 2
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      md_start,
    input  exu_pkg::muldiv_req_t      md_req,
    output logic                      md_done,
    output logic [isa_pkg::xlen-1:0]  md_result
);
    import isa_pkg::*;

    typedef enum logic [1:0] {s_idle, s_busy, s_finish} state_e;

    state_e             state;
    alu_op_e            op_q;
    logic [2*xlen-1:0]  hilo;
    logic               signed_op;
    logic               is_mul;
    logic               is_div;
    logic [xlen-1:0]    mag_a;
    logic [xlen-1:0]    mag_b;
    logic               mul_done;
    logic               div_done;
    logic [2*xlen-1:0]  product;
    logic [2*xlen-1:0]  prod_fix;
    logic [xlen-1:0]    quotient;
    logic [xlen-1:0]    remainder;
    logic [xlen-1:0]    quo_fix;
    logic [xlen-1:0]    rem_fix;
    logic               neg_prod;
    logic               neg_quo;
    logic               neg_rem;

    assign signed_op = md_req.op inside {MULT, MADD, DIV};
    assign is_mul    = md_req.op inside {MULT, MULTU, MADD, MADDU};
    assign is_div    = md_req.op inside {DIV, DIVU};
    assign mag_a     = (signed_op && md_req.a[31]) ? -md_req.a : md_req.a;
    assign mag_b     = (signed_op && md_req.b[31]) ? -md_req.b : md_req.b;

    mul_iter #(
        .MUL_BITS (MUL_BITS)
    ) mul_iter_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (md_start && is_mul),
        .ma      (mag_a),
        .mb      (mag_b),
        .done    (mul_done),
        .product (product)
    );

    div_iter div_iter_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (md_start && is_div),
        .da        (mag_a),
        .db        (mag_b),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    // signs back on; remainder follows the dividend
    assign prod_fix = neg_prod ? -product : product;
    assign quo_fix  = neg_quo ? -quotient : quotient;
    assign rem_fix  = neg_rem ? -remainder : remainder;
    assign md_done  = (state == s_finish);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
            hilo  <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (md_start) begin
                        state <= (is_mul || is_div) ? s_busy : s_finish;
                        if (md_req.op == MTHI) begin
                            hilo[63:32] <= md_req.a;
                        end
                        if (md_req.op == MTLO) begin
                            hilo[31:0] <= md_req.a;
                        end
                    end
                end
                s_busy: begin
                    if (mul_done || div_done) begin
                        state <= s_finish;
                        case (op_q)
                            MULT, MULTU: hilo <= prod_fix;
                            MADD, MADDU: hilo <= hilo + prod_fix;  // wraps
                            default:     hilo <= {rem_fix, quo_fix};
                        endcase
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (md_start) begin
            op_q     <= md_req.op;
            neg_prod <= signed_op && (md_req.a[31] ^ md_req.b[31]);
            neg_quo  <= signed_op && (md_req.a[31] ^ md_req.b[31]) && (md_req.b != '0);
            neg_rem  <= signed_op && md_req.a[31];
            case (md_req.op)
                MFHI:    md_result <= hilo[63:32];
                MFLO:    md_result <= hilo[31:0];
                default: md_result <= '0;
            endcase
        end else if (mul_done && (op_q inside {MULT, MULTU})) begin
            md_result <= prod_fix[31:0];  // low word
        end
    end

endmodule

`default_nettype wire

// ==== logic/alu_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_master #(
    parameter int MUL_BITS = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  exu_pkg::exu_req_t   req,
    output logic                resp_valid,
    input  logic                resp_ready,
    output exu_pkg::exu_resp_t  resp
);
    import isa_pkg::*;
    import exu_pkg::*;

    typedef enum logic [1:0] {s_idle, s_alu, s_md} state_e;

    state_e           state;
    exu_req_t         req_q;
    muldiv_req_t      md_req;
    logic             md_start;
    logic             md_done;
    logic [xlen-1:0]  md_result;
    logic [xlen-1:0]  alu_y;
    logic             alu_ovf;
    logic             accept;

    assign req_ready = (state == s_idle) && !resp_valid;
    assign accept    = req_valid && req_ready;
    assign md_req    = '{op: req_q.op, a: req_q.a, b: req_q.b};

    int_alu int_alu_inst (
        .op       (req_q.op),
        .a        (req_q.a),
        .b        (req_q.b),
        .y        (alu_y),
        .overflow (alu_ovf)
    );

    muldiv_unit #(
        .MUL_BITS (MUL_BITS)
    ) muldiv_unit_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .md_start  (md_start),
        .md_req    (md_req),
        .md_done   (md_done),
        .md_result (md_result)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= s_idle;
            md_start   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            md_start <= accept && is_muldiv(req.op);
            if (resp_valid && resp_ready) begin
                resp_valid <= 1'b0;
            end
            case (state)
                s_idle: begin
                    if (accept) begin
                        state <= is_muldiv(req.op) ? s_md : s_alu;
                    end
                end
                s_alu: begin
                    state      <= s_idle;
                    resp_valid <= 1'b1;
                end
                s_md: begin
                    if (md_done) begin  // stalled until here
                        state      <= s_idle;
                        resp_valid <= 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // resp only loads while no response is pending
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (state == s_alu) begin
            resp <= '{y: alu_y, overflow: alu_ovf};
        end else if (state == s_md && md_done) begin
            resp <= '{y: md_result, overflow: 1'b0};
        end
    end

endmodule

`default_nettype wire

// ==== logic/exec_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_top #(
    parameter int MUL_BITS = 2  // 1, 2 or 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  exu_pkg::exu_req_t   req,
    output logic                resp_valid,
    input  logic                resp_ready,
    output exu_pkg::exu_resp_t  resp
);

    alu_master #(
        .MUL_BITS (MUL_BITS)
    ) alu_master_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

endmodule

`default_nettype wire

// ==== tb/exec_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_checker (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                req_valid,
    input  logic                req_ready,
    input  logic                resp_valid,
    input  logic                resp_ready,
    input  exu_pkg::exu_resp_t  resp,
    input  logic                md_start,
    input  logic                md_done
);
    int fail_cnt;

    initial fail_cnt = 0;

    // response held until taken
    resp_held: assert property (@(posedge clk) disable iff (!arst_n)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp)))
    else begin
        fail_cnt++;
        $error("response changed or dropped before it was taken");
    end

    // one request in flight at a time
    one_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
        (req_valid && req_ready) |=> !req_ready)
    else begin
        fail_cnt++;
        $error("request channel still ready after a request was accepted");
    end

    ready_after_take: assert property (@(posedge clk) disable iff (!arst_n)
        (resp_valid && resp_ready) |=> req_ready)
    else begin
        fail_cnt++;
        $error("request channel not ready after the response was taken");
    end

    reset_state: assert property (@(posedge clk)
        !arst_n |-> (!resp_valid && req_ready && !md_start && !md_done))
    else begin
        fail_cnt++;
        $error("wrong handshake state during reset");
    end

    single_pulses: assert property (@(posedge clk) disable iff (!arst_n)
        (md_start |=> !md_start) and (md_done |=> !md_done))
    else begin
        fail_cnt++;
        $error("muldiv start or done longer than one cycle");
    end

endmodule

`default_nettype wire

// ==== tb/exec_ref.svh ====
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// overflow when the 64-bit sum does not fit back in 32 bits
function automatic logic [31:0] alu_result(alu_op_e op, logic [31:0] a, logic [31:0] b,
                                           output logic ovf);
    longint       s;
    int           sh;
    int           n;
    logic [31:0]  y;
    sh  = int'(a[4:0]);
    n   = 0;
    y   = '0;
    ovf = 1'b0;
    case (op)
        ADD, ADDU: begin
            s   = longint'(int'(a)) + longint'(int'(b));
            y   = 32'(s);
            ovf = (op == ADD) && (s != longint'(int'(y)));
        end
        SUB, SUBU: begin
            s   = longint'(int'(a)) - longint'(int'(b));
            y   = 32'(s);
            ovf = (op == SUB) && (s != longint'(int'(y)));
        end
        SLT:  y = (int'(a) < int'(b)) ? 32'd1 : 32'd0;
        SLTU: y = (a < b) ? 32'd1 : 32'd0;
        AND:  y = a & b;
        OR:   y = a | b;
        NOR:  y = ~(a | b);
        XOR:  y = a ^ b;
        LUI:  y = b << 16;
        SLL:  y = b << sh;
        SRL:  y = b >> sh;
        SRA:  y = 32'(int'(b) >>> sh);
        ROTR: y = (b >> sh) | (b << (32 - sh));  // shift by 32 gives 0
        CLO: begin
            while (n < 32 && a[31 - n]) begin
                n++;
            end
            y = 32'(n);
        end
        CLZ: begin
            while (n < 32 && !a[31 - n]) begin
                n++;
            end
            y = 32'(n);
        end
        default: y = '0;
    endcase
    return y;
endfunction

function automatic logic [63:0] mul_product(logic sgn, logic [31:0] a, logic [31:0] b);
    if (sgn) begin
        return 64'(longint'(int'(a)) * longint'(int'(b)));
    end
    return {32'b0, a} * {32'b0, b};
endfunction

function automatic void div_result(logic sgn, logic [31:0] a, logic [31:0] b,
                                   output logic [31:0] q, output logic [31:0] r);
    longint sa;
    longint sb;
    sa = longint'(int'(a));
    sb = longint'(int'(b));
    if (b == 32'h0) begin  // fixed result instead of a trap
        q = '1;
        r = a;
    end else if (sgn) begin
        q = 32'(sa / sb);  // truncates toward zero
        r = 32'(sa % sb);  // sign of the dividend
    end else begin
        q = a / b;
        r = a % b;
    end
endfunction

`endif

// ==== tb/tb_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_exec;
    import isa_pkg::*;
    import exu_pkg::*;

    `include "exec_ref.svh"

    localparam int     n_req       = 500;
    localparam int     mul_bits    = 2;
    localparam int     mul_lat     = 32 / mul_bits + 3;
    localparam int     div_lat     = 35;
    localparam longint watchdog_ns = (longint'(n_req) * 40 + 10) * 100;

    logic         clk;
    logic         arst_n;
    logic         req_valid;
    logic         req_ready;
    exu_req_t     req;
    logic         resp_valid;
    logic         resp_ready;
    exu_resp_t    resp;

    exu_req_t     reqs [0:n_req-1];
    exu_resp_t    exp_resp [0:n_req-1];
    logic [31:0]  corners [0:4];
    logic [63:0]  model_hilo;  // own copy of hi/lo
    logic [31:0]  rng;
    int           n_built;
    int           resp_idx = 0;
    int           cur_idx;
    alu_op_e      cur_op;
    exu_resp_t    exp_cur;

    exec_top #(
        .MUL_BITS (mul_bits)
    ) exec_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    bind alu_master exec_checker exec_checker_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .md_start   (md_start),
        .md_done    (md_done)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic string op_name(alu_op_e op);
        return op.name();
    endfunction

    task automatic stop_with_failure(string why);
        $display("CHECKS FAILED");
        $fatal(1, "%s", why);
    endtask

    function automatic void push_req(alu_op_e op, logic [31:0] a, logic [31:0] b);
        exu_resp_t    e;
        logic         ovf;
        logic [31:0]  q;
        logic [31:0]  r;
        if (n_built >= n_req) begin
            return;
        end
        e = '0;
        case (op)
            MULT, MULTU: begin
                model_hilo = mul_product(op == MULT, a, b);
                e.y        = model_hilo[31:0];
            end
            MADD, MADDU: model_hilo = model_hilo + mul_product(op == MADD, a, b);  // wraps
            DIV, DIVU: begin
                div_result(op == DIV, a, b, q, r);
                model_hilo = {r, q};
            end
            MTHI: model_hilo[63:32] = a;
            MTLO: model_hilo[31:0] = a;
            MFHI: e.y = model_hilo[63:32];
            MFLO: e.y = model_hilo[31:0];
            default: begin
                e.y        = alu_result(op, a, b, ovf);
                e.overflow = ovf;
            end
        endcase
        reqs[n_built]     = '{op: op, a: a, b: b};
        exp_resp[n_built] = e;
        n_built++;
    endfunction

    function automatic void push_with_readback(alu_op_e op, logic [31:0] a, logic [31:0] b);
        push_req(op, a, b);
        push_req(MFHI, 32'h0, 32'h0);
        push_req(MFLO, 32'h0, 32'h0);
    endfunction

    function automatic void build_stimulus();
        alu_op_e      op;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  r;
        corners = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff};
        push_req(MFHI, 32'h0, 32'h0);  // hi/lo straight out of reset
        push_req(MFLO, 32'h0, 32'h0);
        for (int k = 0; k < 27; k++) begin
            op = alu_op_e'(5'(k));
            if (is_muldiv(op)) begin
                continue;
            end
            for (int i = 0; i < 5; i++) begin
                if (op inside {ADD, SUB, SLT, SLTU, SRA, ROTR}) begin
                    for (int j = 0; j < 5; j++) begin
                        push_req(op, corners[i], corners[j]);
                    end
                end else begin
                    push_req(op, corners[i], corners[4 - i]);
                end
            end
        end
        push_with_readback(MULT, 32'hfffffffd, 32'h7);
        push_with_readback(MULT, 32'h80000000, 32'hffffffff);
        push_with_readback(MULT, 32'h12345678, 32'hf6543211);
        push_with_readback(MULTU, 32'hffffffff, 32'hffffffff);
        push_with_readback(MULTU, 32'h80000000, 32'h3);
        push_req(MTHI, 32'h7fffffff, 32'h0);
        push_req(MTLO, 32'hfffffff0, 32'h0);
        push_with_readback(MADD, 32'hffffffff, 32'h20);
        push_req(MTHI, 32'hffffffff, 32'h0);
        push_req(MTLO, 32'hffffffff, 32'h0);
        push_with_readback(MADDU, 32'hffffffff, 32'hffffffff);
        push_with_readback(DIV, 32'hfffffff9, 32'h2);
        push_with_readback(DIV, 32'h7, 32'hfffffffe);
        push_with_readback(DIV, 32'hfffffff9, 32'hfffffffe);
        push_with_readback(DIV, 32'h80000000, 32'hffffffff);
        push_with_readback(DIV, 32'h64, 32'h0);
        push_with_readback(DIV, 32'hffffff9c, 32'h0);
        push_with_readback(DIVU, 32'hffffffff, 32'ha);
        push_with_readback(DIVU, 32'h5, 32'h0);
        push_with_readback(DIVU, 32'h7, 32'hffffffff);
        // random tail with corners mixed in
        while (n_built < n_req) begin
            r  = next_rand();
            op = alu_op_e'(5'(r % 27));
            a  = next_rand();
            b  = next_rand();
            if (r[8:7] == 2'b00) begin
                a = corners[r[11:9] % 5];
            end
            if (r[13:12] == 2'b00) begin
                b = corners[r[16:14] % 5];
            end
            push_req(op, a, b);
        end
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // back-pressure, low about one cycle in four
    always @(negedge clk) begin
        resp_ready = (next_rand() % 4) != 0;
    end

    always @(posedge clk) begin
        if (arst_n && resp_valid && resp_ready) begin
            resp_idx <= resp_idx + 1;
        end
    end

    always @(negedge clk) begin
        if (exec_top_inst.alu_master_inst.exec_checker_inst.fail_cnt != 0) begin
            stop_with_failure("handshake checker reported a failure");
        end
    end

    assign cur_idx = (resp_idx < n_req) ? resp_idx : n_req - 1;
    assign cur_op  = reqs[cur_idx].op;
    assign exp_cur = exp_resp[cur_idx];

    resp_match: assert property (@(posedge clk) disable iff (!arst_n)
        (resp_valid && resp_ready) |-> (resp == exp_cur))
    else begin
        $display("[ERROR] %0t op %s: y %h ovf %b, expected y %h ovf %b", $time,
                 op_name($sampled(cur_op)), $sampled(resp.y), $sampled(resp.overflow),
                 $sampled(exp_cur.y), $sampled(exp_cur.overflow));
        stop_with_failure("response did not match the reference");
    end

    no_extra_resp: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> (resp_idx < n_req))
    else stop_with_failure("more responses than requests");

    alu_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (req_valid && req_ready && !is_muldiv(req.op)) |-> ##2 resp_valid)
    else stop_with_failure("single-cycle op did not answer one cycle after acceptance");

    move_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (req_valid && req_ready && (req.op inside {MTHI, MTLO, MFHI, MFLO})) |-> ##3 resp_valid)
    else stop_with_failure("HI/LO move did not answer after two cycles");

    mul_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (req_valid && req_ready && (req.op inside {MULT, MULTU, MADD, MADDU}))
        |-> ##(mul_lat + 1) resp_valid)
    else stop_with_failure("multiply did not answer on time");

    div_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (req_valid && req_ready && (req.op inside {DIV, DIVU})) |-> ##(div_lat + 1) resp_valid)
    else stop_with_failure("divide did not answer on time");

    initial begin
        #(watchdog_ns);
        stop_with_failure("run timed out before every response arrived");
    end

    initial begin
        rng        = 32'h4197;
        n_built    = 0;
        model_hilo = '0;
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        build_stimulus();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int k = 0; k < n_req; k++) begin
            req_valid = 1'b1;
            req       = reqs[k];
            while (!req_ready) begin  // ready only moves on a rising edge
                @(negedge clk);
            end
            @(negedge clk);
        end
        req_valid = 1'b0;
        wait (resp_idx == n_req);
        @(negedge clk);
        if (exec_top_inst.alu_master_inst.exec_checker_inst.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_with_failure("handshake checker reported a failure");
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tb
common/isa_pkg.sv
common/exu_pkg.sv
logic/int_alu.sv
muldiv/mul_iter.sv
muldiv/div_iter.sv
muldiv/muldiv_unit.sv
logic/alu_master.sv
logic/exec_top.sv
tb/exec_checker.sv
tb/tb_exec.sv
